// File: common/vga_timing_pkg.sv
`default_nettype none

package vga_timing_pkg;

    ////////////////////
    // Horizontal raster, in pixel clocks
    localparam int H_TOTAL     = 800;
    localparam int H_SYNC_END  = 95;
    localparam int H_ACT_BEGIN = 143;
    localparam int H_ACT_END   = 783;

    ////////////////////
    // Vertical raster, in lines
    localparam int V_TOTAL     = 525;
    localparam int V_SYNC_END  = 1;
    localparam int V_ACT_BEGIN = 34;
    localparam int V_ACT_END   = 514;

    typedef logic [9:0] h_count_t;
    typedef logic [9:0] v_count_t;

    // Coordinates inside the 640x480 picture
    typedef logic [9:0] coord_x_t;
    typedef logic [8:0] coord_y_t;

    // Red in [11:8], green in [7:4], blue in [3:0]
    typedef logic [11:0] rgb_t;

    localparam rgb_t RGB_WHITE = 12'hfff;
    localparam rgb_t RGB_BLACK = 12'h000;

endpackage

`default_nettype wire

// File: common/glyph_pkg.sv
`default_nettype none

package glyph_pkg;

    ////////////////////
    // Bar and box sizes
    localparam int BAR_W      = 16;
    localparam int MID_HALF   = 8;
    localparam int GLYPH_W    = 70;
    localparam int CELL_PITCH = 90;

    // Rows, inclusive
    localparam int GLYPH_TOP = 170;
    localparam int GLYPH_BOT = 309;
    localparam int MID_Y     = 239;

    // Left edges of the boxes and the separator
    localparam int PLACE0_LEFT = 10;
    localparam int SEP_LEFT    = 90;
    localparam int DIGIT1_LEFT = 190;

    localparam int N_PLACES = 6;

    typedef logic [3:0] digit_t;
    typedef logic [6:0] seg_mask_t;

    // Bit positions within seg_mask_t
    localparam int SEG_TOP = 0;
    localparam int SEG_UR  = 1;
    localparam int SEG_LR  = 2;
    localparam int SEG_BOT = 3;
    localparam int SEG_LL  = 4;
    localparam int SEG_UL  = 5;
    localparam int SEG_MID = 6;

    ////////////////////
    // Masks written as {mid, ul, ll, bot, lr, ur, top}
    localparam seg_mask_t SEG_TABLE [16] = '{
        7'b0111111, 7'b0000110, 7'b1011011, 7'b1001111,
        7'b1100110, 7'b1101101, 7'b1111101, 7'b0000111,
        7'b1111111, 7'b1101111,
        // Codes 10 to 15 stay dark
        7'b0000000, 7'b0000000, 7'b0000000,
        7'b0000000, 7'b0000000, 7'b0000000
    };

endpackage

`default_nettype wire

// File: hdl/scan_counter.sv
`timescale 1ns/1ps
`default_nettype none

module scan_counter
(
    input  wire                       vga_clk,
    input  wire                       arst_n,
    output vga_timing_pkg::h_count_t  h_count,
    output vga_timing_pkg::v_count_t  v_count
);

    logic h_wrap;
    logic v_wrap;

    assign h_wrap = (h_count == vga_timing_pkg::h_count_t'(vga_timing_pkg::H_TOTAL - 1));
    assign v_wrap = (v_count == vga_timing_pkg::v_count_t'(vga_timing_pkg::V_TOTAL - 1));

    always_ff @(posedge vga_clk or negedge arst_n)
    begin
        if (!arst_n)
            h_count <= '0;
        else if (h_wrap)
            h_count <= '0;
        else
            h_count <= h_count + 1'b1;
    end

    // Line counter steps at the end of each line
    always_ff @(posedge vga_clk or negedge arst_n)
    begin
        if (!arst_n)
            v_count <= '0;
        else if (h_wrap)
        begin
            if (v_wrap)
                v_count <= '0;
            else
                v_count <= v_count + 1'b1;
        end
    end

    ////////////////////
    a_h_range: assert property (@(posedge vga_clk) disable iff (!arst_n)
        h_count <= vga_timing_pkg::H_TOTAL - 1);

    a_v_range: assert property (@(posedge vga_clk) disable iff (!arst_n)
        v_count <= vga_timing_pkg::V_TOTAL - 1);

endmodule

`default_nettype wire

// File: hdl/sync_decode.sv
`timescale 1ns/1ps
`default_nettype none

module sync_decode
(
    input  wire                       vga_clk,
    input  wire                       arst_n,
    input  vga_timing_pkg::h_count_t  h_count,
    input  vga_timing_pkg::v_count_t  v_count,
    output logic                      hsync,
    output logic                      vsync,
    output logic                      active,
    output vga_timing_pkg::coord_x_t  px,
    output vga_timing_pkg::coord_y_t  py
);

    logic h_act;
    logic v_act;

    assign h_act = (h_count >= vga_timing_pkg::H_ACT_BEGIN) &&
                   (h_count < vga_timing_pkg::H_ACT_END);
    assign v_act = (v_count >= vga_timing_pkg::V_ACT_BEGIN) &&
                   (v_count < vga_timing_pkg::V_ACT_END);

    // Sync pulses are low at the start of line and frame
    always_ff @(posedge vga_clk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            hsync  <= 1'b0;
            vsync  <= 1'b0;
            active <= 1'b0;
        end
        else
        begin
            hsync  <= (h_count > vga_timing_pkg::H_SYNC_END);
            vsync  <= (v_count > vga_timing_pkg::V_SYNC_END);
            active <= h_act && v_act;
        end
    end

    // Only meaningful while active is set
    always_ff @(posedge vga_clk)
    begin
        px <= vga_timing_pkg::coord_x_t'(h_count - vga_timing_pkg::H_ACT_BEGIN);
        py <= vga_timing_pkg::coord_y_t'(v_count - vga_timing_pkg::V_ACT_BEGIN);
    end

    ////////////////////
    a_coord_range: assert property (@(posedge vga_clk) disable iff (!arst_n)
        active |-> (px < vga_timing_pkg::H_ACT_END - vga_timing_pkg::H_ACT_BEGIN) &&
                   (py < vga_timing_pkg::V_ACT_END - vga_timing_pkg::V_ACT_BEGIN));

endmodule

`default_nettype wire

// File: glyph/segment_hit.sv
`timescale 1ns/1ps
`default_nettype none

module segment_hit
(
    input  vga_timing_pkg::coord_x_t  lx,
    input  vga_timing_pkg::coord_y_t  py,
    input  glyph_pkg::seg_mask_t      mask,
    output logic                      hit
);

    logic col_left;
    logic col_right;
    logic full_w;
    logic rows_upper;
    logic rows_lower;
    logic rows_top;
    logic rows_mid;
    logic rows_bot;
    glyph_pkg::seg_mask_t on_bar;

    ////////////////////
    // Columns across the box
    assign col_left  = (lx < glyph_pkg::BAR_W);
    assign col_right = (lx >= glyph_pkg::GLYPH_W - glyph_pkg::BAR_W) &&
                       (lx < glyph_pkg::GLYPH_W);
    assign full_w    = (lx < glyph_pkg::GLYPH_W);

    ////////////////////
    // Row bands, all inclusive
    assign rows_upper = (py >= glyph_pkg::GLYPH_TOP) &&
                        (py <= glyph_pkg::MID_Y + glyph_pkg::MID_HALF);
    assign rows_lower = (py >= glyph_pkg::MID_Y - glyph_pkg::MID_HALF + 1) &&
                        (py <= glyph_pkg::GLYPH_BOT);
    assign rows_top   = (py >= glyph_pkg::GLYPH_TOP) &&
                        (py <= glyph_pkg::GLYPH_TOP + glyph_pkg::BAR_W - 1);
    assign rows_mid   = (py >= glyph_pkg::MID_Y - glyph_pkg::MID_HALF + 1) &&
                        (py <= glyph_pkg::MID_Y + glyph_pkg::MID_HALF);
    assign rows_bot   = (py >= glyph_pkg::GLYPH_BOT - glyph_pkg::BAR_W + 1) &&
                        (py <= glyph_pkg::GLYPH_BOT);

    // Which bar rectangles contain the pixel
    always_comb
    begin
        on_bar                     = '0;
        on_bar[glyph_pkg::SEG_TOP] = rows_top && full_w;
        on_bar[glyph_pkg::SEG_UR]  = rows_upper && col_right;
        on_bar[glyph_pkg::SEG_LR]  = rows_lower && col_right;
        on_bar[glyph_pkg::SEG_BOT] = rows_bot && full_w;
        on_bar[glyph_pkg::SEG_LL]  = rows_lower && col_left;
        on_bar[glyph_pkg::SEG_UL]  = rows_upper && col_left;
        on_bar[glyph_pkg::SEG_MID] = rows_mid && full_w;
    end

    // Lit only where the bar is enabled by the mask
    assign hit = |(on_bar & mask);

endmodule

`default_nettype wire

// File: glyph/glyph_renderer.sv
`timescale 1ns/1ps
`default_nettype none

module glyph_renderer
(
    input  wire                       vga_clk,
    input  wire                       arst_n,
    input  wire                       clear,
    input  wire                       place0,
    input  glyph_pkg::digit_t         d1,
    input  glyph_pkg::digit_t         d2,
    input  glyph_pkg::digit_t         d3,
    input  glyph_pkg::digit_t         d4,
    input  glyph_pkg::digit_t         d5,
    input  wire                       active,
    input  vga_timing_pkg::coord_x_t  px,
    input  vga_timing_pkg::coord_y_t  py,
    input  wire                       hsync_in,
    input  wire                       vsync_in,
    output vga_timing_pkg::rgb_t      rgb,
    output logic                      hsync,
    output logic                      vsync
);

    glyph_pkg::digit_t        place_digit [glyph_pkg::N_PLACES];
    vga_timing_pkg::coord_x_t lx;
    glyph_pkg::seg_mask_t     mask;
    logic                     seg_lit;
    logic                     sep_lit;
    logic                     white;

    // Left edge of box k
    function automatic int box_left(input int k);
        return (k == 0) ? glyph_pkg::PLACE0_LEFT
                        : glyph_pkg::DIGIT1_LEFT + glyph_pkg::CELL_PITCH * (k - 1);
    endfunction

    assign place_digit[0] = glyph_pkg::digit_t'(place0);
    assign place_digit[1] = d1;
    assign place_digit[2] = d2;
    assign place_digit[3] = d3;
    assign place_digit[4] = d4;
    assign place_digit[5] = d5;

    ////////////////////
    // Box under the pixel, empty mask between boxes
    always_comb
    begin
        lx   = '0;
        mask = '0;
        for (int k = 0; k < glyph_pkg::N_PLACES; k++)
        begin
            if ((px >= box_left(k)) && (px < box_left(k) + glyph_pkg::GLYPH_W))
            begin
                lx   = vga_timing_pkg::coord_x_t'(px - box_left(k));
                mask = glyph_pkg::SEG_TABLE[place_digit[k]];
            end
        end
    end

    segment_hit u_segment_hit
    (
        .lx   (lx),
        .py   (py),
        .mask (mask),
        .hit  (seg_lit)
    );

    // Underscore between place 0 and digit 1
    assign sep_lit = (px >= glyph_pkg::SEP_LEFT) &&
                     (px < glyph_pkg::SEP_LEFT + glyph_pkg::BAR_W) &&
                     (py >= glyph_pkg::GLYPH_BOT - glyph_pkg::BAR_W + 1) &&
                     (py <= glyph_pkg::GLYPH_BOT);

    assign white = (seg_lit || sep_lit) && active && !clear;

    ////////////////////
    always_ff @(posedge vga_clk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            rgb   <= vga_timing_pkg::RGB_BLACK;
            hsync <= 1'b0;
            vsync <= 1'b0;
        end
        else
        begin
            rgb   <= white ? vga_timing_pkg::RGB_WHITE : vga_timing_pkg::RGB_BLACK;
            hsync <= hsync_in;
            vsync <= vsync_in;
        end
    end

    a_blank_outside: assert property (@(posedge vga_clk) disable iff (!arst_n)
        !active |=> (rgb == vga_timing_pkg::RGB_BLACK));

endmodule

`default_nettype wire

// File: hdl/vga_digit_display.sv
`timescale 1ns/1ps
`default_nettype none

module vga_digit_display
(
    input  wire                   vga_clk,
    input  wire                   arst_n,
    input  wire                   clear,
    input  wire                   place0,
    input  glyph_pkg::digit_t     d1,
    input  glyph_pkg::digit_t     d2,
    input  glyph_pkg::digit_t     d3,
    input  glyph_pkg::digit_t     d4,
    input  glyph_pkg::digit_t     d5,
    output vga_timing_pkg::rgb_t  rgb,
    output logic                  hsync,
    output logic                  vsync
);

    vga_timing_pkg::h_count_t h_count;
    vga_timing_pkg::v_count_t v_count;
    vga_timing_pkg::coord_x_t px;
    vga_timing_pkg::coord_y_t py;
    logic                     active;
    logic                     hsync_dec;
    logic                     vsync_dec;

    scan_counter u_scan_counter
    (
        .vga_clk (vga_clk),
        .arst_n  (arst_n),
        .h_count (h_count),
        .v_count (v_count)
    );

    // Stage 1 decode
    sync_decode u_sync_decode
    (
        .vga_clk (vga_clk),
        .arst_n  (arst_n),
        .h_count (h_count),
        .v_count (v_count),
        .hsync   (hsync_dec),
        .vsync   (vsync_dec),
        .active  (active),
        .px      (px),
        .py      (py)
    );

    // Stage 2 colour and aligned syncs
    glyph_renderer u_glyph_renderer
    (
        .vga_clk  (vga_clk),
        .arst_n   (arst_n),
        .clear    (clear),
        .place0   (place0),
        .d1       (d1),
        .d2       (d2),
        .d3       (d3),
        .d4       (d4),
        .d5       (d5),
        .active   (active),
        .px       (px),
        .py       (py),
        .hsync_in (hsync_dec),
        .vsync_in (vsync_dec),
        .rgb      (rgb),
        .hsync    (hsync),
        .vsync    (vsync)
    );

endmodule

`default_nettype wire

// File: bench/tb_vga_digit_display.sv
`timescale 1ns/1ps
`default_nettype none

module tb_vga_digit_display;

    localparam int RESET_CYCLES = 10;
    localparam int FRAME_CYCLES = 800 * 525;
    localparam int N_FRAMES     = 4;
    localparam int LIMIT_NS     = (RESET_CYCLES + FRAME_CYCLES * N_FRAMES) * 12;
    localparam int MAX_PRINTS   = 50;

    // One bit per bar
    localparam logic [6:0] B_TOP = 7'h01;
    localparam logic [6:0] B_UR  = 7'h02;
    localparam logic [6:0] B_LR  = 7'h04;
    localparam logic [6:0] B_BOT = 7'h08;
    localparam logic [6:0] B_LL  = 7'h10;
    localparam logic [6:0] B_UL  = 7'h20;
    localparam logic [6:0] B_MID = 7'h40;
    localparam logic [6:0] B_ALL = 7'h7f;

    logic                 vga_clk;
    logic                 arst_n;
    logic                 clear;
    logic                 place0;
    glyph_pkg::digit_t    d1;
    glyph_pkg::digit_t    d2;
    glyph_pkg::digit_t    d3;
    glyph_pkg::digit_t    d4;
    glyph_pkg::digit_t    d5;
    vga_timing_pkg::rgb_t rgb;
    logic                 hsync;
    logic                 vsync;

    logic [15:0]          lfsr_state;
    int                   mh;
    int                   mv;
    vga_timing_pkg::rgb_t exp_rgb [2];
    logic                 exp_hs [2];
    logic                 exp_vs [2];
    logic                 exp_act [2];
    int                   test_errs [1:6];
    string                test_name [1:6];
    int                   checks;
    int                   errors;
    int                   printed;

    vga_digit_display uut
    (
        .vga_clk (vga_clk),
        .arst_n  (arst_n),
        .clear   (clear),
        .place0  (place0),
        .d1      (d1),
        .d2      (d2),
        .d3      (d3),
        .d4      (d4),
        .d5      (d5),
        .rgb     (rgb),
        .hsync   (hsync),
        .vsync   (vsync)
    );

    always #5 vga_clk = ~vga_clk;

    ////////////////////
    // Random source, taps 16 14 13 11
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    task automatic take_bits(input int n, output int val);
        val = 0;
        for (int i = 0; i < n; i++)
        begin
            lfsr_state = lfsr_next(lfsr_state);
            val = (val << 1) | lfsr_state[0];
        end
    endtask

    // Frame 1 uses the blank codes, frame 2 any code
    task automatic draw_digit(input int f, output glyph_pkg::digit_t d);
        int r;
        take_bits(4, r);
        if (f == 1)
            d = glyph_pkg::digit_t'(10 + r % 6);
        else if (f == 2)
            d = glyph_pkg::digit_t'(r);
        else
            d = glyph_pkg::digit_t'(r % 10);
    endtask

    ////////////////////
    // Reference model
    function automatic logic [6:0] bars_of(input glyph_pkg::digit_t d);
        case (d)
            4'd0:    return B_ALL & ~B_MID;
            4'd1:    return B_UR | B_LR;
            4'd2:    return B_TOP | B_UR | B_MID | B_LL | B_BOT;
            4'd3:    return B_TOP | B_UR | B_MID | B_LR | B_BOT;
            4'd4:    return B_UL | B_MID | B_UR | B_LR;
            4'd5:    return B_TOP | B_UL | B_MID | B_LR | B_BOT;
            4'd6:    return B_ALL & ~B_UR;
            4'd7:    return B_TOP | B_UR | B_LR;
            4'd8:    return B_ALL;
            4'd9:    return B_ALL & ~B_LL;
            default: return 7'h00;
        endcase
    endfunction

    function automatic logic bar_hit(input int lx, input int y, input logic [6:0] m);
        logic left;
        logic right;
        logic upper;
        logic lower;
        left  = (lx <= 15);
        right = (lx >= 54) && (lx <= 69);
        upper = (y >= 170) && (y <= 247);
        lower = (y >= 232) && (y <= 309);
        return ((m & B_TOP) != 0 && y >= 170 && y <= 185) ||
               ((m & B_UR) != 0 && upper && right) ||
               ((m & B_LR) != 0 && lower && right) ||
               ((m & B_BOT) != 0 && y >= 294 && y <= 309) ||
               ((m & B_LL) != 0 && lower && left) ||
               ((m & B_UL) != 0 && upper && left) ||
               ((m & B_MID) != 0 && y >= 232 && y <= 247);
    endfunction

    function automatic logic in_active(input int h, input int v);
        return (h >= 143) && (h < 783) && (v >= 34) && (v < 514);
    endfunction

    function automatic logic model_white(input int h, input int v);
        int                x;
        int                y;
        int                left;
        logic              lit;
        glyph_pkg::digit_t dig [6];
        if (!in_active(h, v) || clear)
            return 1'b0;
        x = h - 143;
        y = v - 34;
        dig[0] = glyph_pkg::digit_t'(place0);
        dig[1] = d1;
        dig[2] = d2;
        dig[3] = d3;
        dig[4] = d4;
        dig[5] = d5;
        // Separator underscore
        lit = (x >= 90) && (x <= 105) && (y >= 294) && (y <= 309);
        for (int k = 0; k < 6; k++)
        begin
            left = (k == 0) ? 10 : 190 + 90 * (k - 1);
            if ((x >= left) && (x <= left + 69))
                lit = lit | bar_hit(x - left, y, bars_of(dig[k]));
        end
        return lit;
    endfunction

    // One clock, with the two-stage prediction pipe
    task automatic step_cycle();
        @(posedge vga_clk);
        exp_rgb[1] = exp_rgb[0];
        exp_hs[1]  = exp_hs[0];
        exp_vs[1]  = exp_vs[0];
        exp_act[1] = exp_act[0];
        exp_rgb[0] = model_white(mh, mv) ? vga_timing_pkg::RGB_WHITE
                                         : vga_timing_pkg::RGB_BLACK;
        exp_hs[0]  = (mh > 95);
        exp_vs[0]  = (mv > 1);
        exp_act[0] = in_active(mh, mv);
        if (mh == 799)
        begin
            mh = 0;
            mv = (mv == 524) ? 0 : mv + 1;
        end
        else
            mh = mh + 1;
        #1;
    endtask

    ////////////////////
    task automatic log_error(input int test_id);
        errors++;
        test_errs[test_id]++;
        printed++;
    endtask

    task automatic check_rgb(input vga_timing_pkg::rgb_t got, input vga_timing_pkg::rgb_t exp,
                             input int test_id, input string what);
        checks++;
        if (got !== exp)
        begin
            log_error(test_id);
            if (printed <= MAX_PRINTS)
                $display("CHECK FAILED at %0t: %s, rgb %h expected %h", $time, what, got, exp);
        end
    endtask

    task automatic check_sync(input logic got, input logic exp, input int test_id,
                              input string what);
        checks++;
        if (got !== exp)
        begin
            log_error(test_id);
            if (printed <= MAX_PRINTS)
                $display("CHECK FAILED at %0t: %s is %b expected %b", $time, what, got, exp);
        end
    endtask

    task automatic check_count(input int got, input int exp, input int test_id,
                               input string what);
        checks++;
        if (got != exp)
        begin
            log_error(test_id);
            $display("CHECK FAILED at %0t: %s is %0d expected %0d", $time, what, got, exp);
        end
    endtask

    task automatic report_test(input int test_id);
        if (test_errs[test_id] == 0)
            $display("test %0d, %s: ok", test_id, test_name[test_id]);
        else
            $display("test %0d, %s: %0d errors", test_id, test_name[test_id],
                     test_errs[test_id]);
    endtask

    // New values at the start of a frame, while v_count is 0
    task automatic drive_frame(input int f);
        int r;
        if (f == 0 || f == 3)
            place0 = (f == 3);
        else
        begin
            take_bits(1, r);
            place0 = r[0];
        end
        clear = (f == 2);
        draw_digit(f, d1);
        draw_digit(f, d2);
        draw_digit(f, d3);
        draw_digit(f, d4);
        draw_digit(f, d5);
    endtask

    function automatic int frame_test(input int f);
        return (f == 1) ? 4 : (f == 2) ? 5 : 3;
    endfunction

    ////////////////////
    initial
    begin
        int n;
        int hs_low;
        int vs_low;
        int whites;
        vga_clk    = 1'b0;
        arst_n     = 1'b0;
        clear      = 1'b0;
        place0     = 1'b0;
        d1         = '0;
        d2         = '0;
        d3         = '0;
        d4         = '0;
        d5         = '0;
        lfsr_state = 16'd12;
        mh         = 0;
        mv         = 0;
        checks     = 0;
        errors     = 0;
        printed    = 0;
        n          = 0;
        for (int i = 0; i < 2; i++)
        begin
            exp_rgb[i] = vga_timing_pkg::RGB_BLACK;
            exp_hs[i]  = 1'b0;
            exp_vs[i]  = 1'b0;
            exp_act[i] = 1'b0;
        end
        for (int i = 1; i <= 6; i++)
            test_errs[i] = 0;
        test_name[1] = "reset state";
        test_name[2] = "sync timing";
        test_name[3] = "pixel content";
        test_name[4] = "blank codes";
        test_name[5] = "clear";
        test_name[6] = "blanking";

        repeat (RESET_CYCLES)
        begin
            @(posedge vga_clk);
            #1;
            check_rgb(rgb, vga_timing_pkg::RGB_BLACK, 1, "rgb in reset");
            check_sync(hsync, 1'b0, 1, "hsync in reset");
            check_sync(vsync, 1'b0, 1, "vsync in reset");
        end
        arst_n = 1'b1;

        for (int f = 0; f < N_FRAMES; f++)
        begin
            drive_frame(f);
            hs_low = 0;
            vs_low = 0;
            whites = 0;
            repeat (FRAME_CYCLES)
            begin
                step_cycle();
                check_rgb(rgb, exp_rgb[1], frame_test(f), "pixel");
                check_sync(hsync, exp_hs[1], 2, "hsync");
                check_sync(vsync, exp_vs[1], 2, "vsync");
                if (!exp_act[1])
                    check_rgb(rgb, vga_timing_pkg::RGB_BLACK, 6, "outside active area");
                if (n < 2)
                begin
                    check_rgb(rgb, vga_timing_pkg::RGB_BLACK, 1, "rgb after reset");
                    check_sync(hsync, 1'b0, 1, "hsync after reset");
                    check_sync(vsync, 1'b0, 1, "vsync after reset");
                end
                if (n == 1)
                    report_test(1);
                hs_low += (hsync === 1'b0);
                vs_low += (vsync === 1'b0);
                whites += (rgb === vga_timing_pkg::RGB_WHITE);
                n++;
            end
            // Frame 0 opens with the reset value of the output pipe
            if (f > 0)
            begin
                check_count(hs_low, 96 * 525, 2, "hsync low cycles per frame");
                check_count(vs_low, 2 * 800, 2, "vsync low cycles per frame");
            end
            if (f == 1)
                report_test(4);
            if (f == 2)
            begin
                check_count(whites, 0, 5, "white pixels while clear");
                report_test(5);
            end
        end
        report_test(3);
        report_test(2);
        report_test(6);
        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0)
            $display(">>> PASS");
        else
            $display(">>> FAIL");
        $finish;
    end

    initial
    begin
        #(LIMIT_NS);
        $display("Run timed out before all frames were checked");
        $display(">>> FAIL");
        $finish;
    end

endmodule

`default_nettype wire

// File: build.f
common/vga_timing_pkg.sv
common/glyph_pkg.sv
hdl/scan_counter.sv
hdl/sync_decode.sv
glyph/segment_hit.sv
glyph/glyph_renderer.sv
hdl/vga_digit_display.sv
bench/tb_vga_digit_display.sv
